// File: hw/round_trip_pkg.sv
`default_nettype none

package round_trip_pkg;

    localparam int data_w = 32;
    localparam int host_addr_w = 64;
    localparam int reg_addr_w = 12;
    localparam int words = 8;
    localparam int word_idx_w = 3;
    localparam logic [host_addr_w-1:0] bytes_per_word = 4;

    localparam logic [reg_addr_w-1:0] reg_ctrl = 12'h000;
    localparam logic [reg_addr_w-1:0] reg_base_lo = 12'h018;
    localparam logic [reg_addr_w-1:0] reg_base_hi = 12'h01C;

    typedef struct packed {
        logic [data_w-2:0] ignored;
        logic start;
    } ctrl_write_t;

    typedef struct packed {
        logic [data_w-4:0] zero;
        logic idle;
        logic done;
        logic start;
    } ctrl_read_t;

    // The control word means start on write and status on read.
    typedef union packed {
        ctrl_write_t wr;
        ctrl_read_t rd;
    } ctrl_word_u;

    typedef enum logic [1:0] {
        phase_idle,
        phase_fetch,
        phase_writeback
    } seq_phase_e;

endpackage

`default_nettype wire

// File: hw/buffer_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface buffer_port_if;

    logic [round_trip_pkg::word_idx_w-1:0] idx;
    logic [round_trip_pkg::data_w-1:0] wdata;
    logic we;
    logic [round_trip_pkg::data_w-1:0] rdata;

    modport client (
        output idx,
        output wdata,
        output we,
        input  rdata
    );

    modport mem (
        input  idx,
        input  wdata,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

// File: hw/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
    input  wire ACLK,
    input  wire ARESET,
    input  wire s_axi_arvalid,
    output logic s_axi_arready,
    input  wire [round_trip_pkg::reg_addr_w-1:0] s_axi_araddr,
    output logic s_axi_rvalid,
    input  wire s_axi_rready,
    output logic [round_trip_pkg::data_w-1:0] s_axi_rdata,
    input  wire s_axi_awvalid,
    output logic s_axi_awready,
    input  wire [round_trip_pkg::reg_addr_w-1:0] s_axi_awaddr,
    input  wire s_axi_wvalid,
    output logic s_axi_wready,
    input  wire [round_trip_pkg::data_w-1:0] s_axi_wdata,
    output logic s_axi_bvalid,
    input  wire s_axi_bready,
    input  wire done,
    output logic start,
    output logic [round_trip_pkg::host_addr_w-1:0] base
);

    logic rvalid_q;
    logic [round_trip_pkg::reg_addr_w-1:0] raddr_q;
    logic [round_trip_pkg::data_w-1:0] rdata_q;
    logic w_pend;
    logic b_pend;
    logic [round_trip_pkg::reg_addr_w-1:0] waddr_q;
    logic start_q;
    logic done_q;
    logic idle_q;
    logic [round_trip_pkg::data_w-1:0] base_lo_q;
    logic [round_trip_pkg::data_w-1:0] base_hi_q;
    round_trip_pkg::ctrl_word_u wr_word;
    round_trip_pkg::ctrl_word_u status;
    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign ar_hs = s_axi_arvalid && s_axi_arready;
    assign r_hs = s_axi_rvalid && s_axi_rready;
    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs = s_axi_wvalid && s_axi_wready;
    assign b_hs = s_axi_bvalid && s_axi_bready;

    assign s_axi_arready = !rvalid_q;
    assign s_axi_rvalid = rvalid_q;
    assign s_axi_rdata = rdata_q;
    assign s_axi_awready = !w_pend && !b_pend;
    assign s_axi_wready = w_pend;
    assign s_axi_bvalid = b_pend;

    assign wr_word = s_axi_wdata;
    assign start = start_q;
    assign base = {base_hi_q, base_lo_q};

    always_comb begin
        status = '0;
        status.rd.start = start_q;
        status.rd.done = done_q;
        status.rd.idle = idle_q;
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            rvalid_q <= 1'b0;
        end else if (ar_hs) begin
            rvalid_q <= 1'b1;
        end else if (r_hs) begin
            rvalid_q <= 1'b0;
        end
    end

    // Read data is captured together with the address and held until rready.
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            raddr_q <= s_axi_araddr;
            case (s_axi_araddr)
                round_trip_pkg::reg_ctrl: rdata_q <= status;
                round_trip_pkg::reg_base_lo: rdata_q <= base_lo_q;
                round_trip_pkg::reg_base_hi: rdata_q <= base_hi_q;
                default: rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            w_pend <= 1'b0;
            b_pend <= 1'b0;
        end else if (aw_hs) begin
            w_pend <= 1'b1;
        end else if (w_hs) begin
            w_pend <= 1'b0;
            b_pend <= 1'b1;
        end else if (b_hs) begin
            b_pend <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            waddr_q <= s_axi_awaddr;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            start_q <= 1'b0;
            done_q <= 1'b0;
            idle_q <= 1'b1;
            base_lo_q <= '0;
            base_hi_q <= '0;
        end else begin
            if (done) begin
                start_q <= 1'b0;
            end else if (w_hs && waddr_q == round_trip_pkg::reg_ctrl && wr_word.wr.start) begin
                start_q <= 1'b1;
            end
            // Done is sticky until the host reads the control word.
            if (done) begin
                done_q <= 1'b1;
            end else if (r_hs && raddr_q == round_trip_pkg::reg_ctrl) begin
                done_q <= 1'b0;
            end
            if (done) begin
                idle_q <= 1'b1;
            end else if (start_q) begin
                idle_q <= 1'b0;
            end
            if (w_hs && waddr_q == round_trip_pkg::reg_base_lo) begin
                base_lo_q <= s_axi_wdata;
            end
            if (w_hs && waddr_q == round_trip_pkg::reg_base_hi) begin
                base_hi_q <= s_axi_wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/transfer_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module transfer_sequencer (
    input  wire ACLK,
    input  wire ARESET,
    input  wire start,
    input  wire [round_trip_pkg::host_addr_w-1:0] base,
    output logic done,
    output logic fetch_go,
    input  wire fetch_finished,
    output logic wb_go,
    input  wire wb_finished,
    output logic [round_trip_pkg::host_addr_w-1:0] run_base,
    buffer_port_if.mem fetch_port,
    buffer_port_if.mem wb_port,
    buffer_port_if.client buf_port
);

    round_trip_pkg::seq_phase_e phase;

    // The pulses are combinational so that start is cleared on the same edge
    // that returns the sequencer to idle.
    assign fetch_go = phase == round_trip_pkg::phase_idle && start;
    assign wb_go = phase == round_trip_pkg::phase_fetch && fetch_finished;
    assign done = phase == round_trip_pkg::phase_writeback && wb_finished;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            phase <= round_trip_pkg::phase_idle;
        end else if (fetch_go) begin
            phase <= round_trip_pkg::phase_fetch;
        end else if (wb_go) begin
            phase <= round_trip_pkg::phase_writeback;
        end else if (done) begin
            phase <= round_trip_pkg::phase_idle;
        end
    end

    // The base is frozen for the whole run.
    always_ff @(posedge ACLK) begin
        if (fetch_go) begin
            run_base <= base;
        end
    end

    always_comb begin
        buf_port.idx = '0;
        buf_port.wdata = '0;
        buf_port.we = 1'b0;
        case (phase)
            round_trip_pkg::phase_fetch: begin
                buf_port.idx = fetch_port.idx;
                buf_port.wdata = fetch_port.wdata;
                buf_port.we = fetch_port.we;
            end
            round_trip_pkg::phase_writeback: begin
                buf_port.idx = wb_port.idx;
                buf_port.wdata = wb_port.wdata;
                buf_port.we = wb_port.we;
            end
            default: begin
            end
        endcase
    end

    assign fetch_port.rdata = buf_port.rdata;
    assign wb_port.rdata = buf_port.rdata;

endmodule

`default_nettype wire

// File: hw/fetch_engine.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_engine (
    input  wire ACLK,
    input  wire ARESET,
    input  wire go,
    input  wire [round_trip_pkg::host_addr_w-1:0] base,
    output logic finished,
    output logic m_axi_arvalid,
    input  wire m_axi_arready,
    output logic [round_trip_pkg::host_addr_w-1:0] m_axi_araddr,
    input  wire m_axi_rvalid,
    output logic m_axi_rready,
    input  wire [round_trip_pkg::data_w-1:0] m_axi_rdata,
    buffer_port_if.client buf_port
);

    logic [round_trip_pkg::word_idx_w-1:0] idx;
    logic [round_trip_pkg::host_addr_w-1:0] offset;
    logic r_hs;

    assign r_hs = m_axi_rvalid && m_axi_rready;
    assign offset = idx * round_trip_pkg::bytes_per_word;
    assign m_axi_araddr = base + offset;

    // Each returned word lands in the buffer on its r handshake.
    assign buf_port.idx = idx;
    assign buf_port.wdata = m_axi_rdata;
    assign buf_port.we = r_hs;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            idx <= '0;
            m_axi_arvalid <= 1'b0;
            m_axi_rready <= 1'b0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (go) begin
                idx <= '0;
                m_axi_arvalid <= 1'b1;
            end else if (m_axi_arvalid && m_axi_arready) begin
                m_axi_arvalid <= 1'b0;
                m_axi_rready <= 1'b1;
            end else if (r_hs) begin
                m_axi_rready <= 1'b0;
                if (int'(idx) == round_trip_pkg::words - 1) begin
                    finished <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                    m_axi_arvalid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/writeback_engine.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_engine (
    input  wire ACLK,
    input  wire ARESET,
    input  wire go,
    input  wire [round_trip_pkg::host_addr_w-1:0] base,
    output logic finished,
    output logic m_axi_awvalid,
    input  wire m_axi_awready,
    output logic [round_trip_pkg::host_addr_w-1:0] m_axi_awaddr,
    output logic m_axi_wvalid,
    input  wire m_axi_wready,
    output logic [round_trip_pkg::data_w-1:0] m_axi_wdata,
    input  wire m_axi_bvalid,
    output logic m_axi_bready,
    buffer_port_if.client buf_port
);

    logic [round_trip_pkg::word_idx_w-1:0] idx;
    logic [round_trip_pkg::host_addr_w-1:0] offset;

    assign offset = idx * round_trip_pkg::bytes_per_word;
    assign m_axi_awaddr = base + offset;

    // The buffer is only read here, so the write side of the port stays idle.
    assign buf_port.idx = idx;
    assign buf_port.wdata = '0;
    assign buf_port.we = 1'b0;
    assign m_axi_wdata = buf_port.rdata;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            idx <= '0;
            m_axi_awvalid <= 1'b0;
            m_axi_wvalid <= 1'b0;
            m_axi_bready <= 1'b0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (go) begin
                idx <= '0;
                m_axi_awvalid <= 1'b1;
            end else if (m_axi_awvalid && m_axi_awready) begin
                m_axi_awvalid <= 1'b0;
                m_axi_wvalid <= 1'b1;
            end else if (m_axi_wvalid && m_axi_wready) begin
                m_axi_wvalid <= 1'b0;
                m_axi_bready <= 1'b1;
            end else if (m_axi_bvalid && m_axi_bready) begin
                // The index only moves once the write response is back.
                m_axi_bready <= 1'b0;
                if (int'(idx) == round_trip_pkg::words - 1) begin
                    finished <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                    m_axi_awvalid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/word_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module word_buffer (
    input wire ACLK,
    buffer_port_if.mem port
);

    logic [round_trip_pkg::data_w-1:0] mem [round_trip_pkg::words];

    always_ff @(posedge ACLK) begin
        if (port.we) begin
            mem[port.idx] <= port.wdata;
        end
    end

    // Combinational read feeds the host write data directly.
    assign port.rdata = mem[port.idx];

endmodule

`default_nettype wire

// File: hw/round_trip_top.sv
`timescale 1ns/1ps
`default_nettype none

module round_trip_top (
    input  wire ACLK,
    input  wire ARESET,
    input  wire s_axi_arvalid,
    output wire s_axi_arready,
    input  wire [round_trip_pkg::reg_addr_w-1:0] s_axi_araddr,
    output wire s_axi_rvalid,
    input  wire s_axi_rready,
    output wire [round_trip_pkg::data_w-1:0] s_axi_rdata,
    input  wire s_axi_awvalid,
    output wire s_axi_awready,
    input  wire [round_trip_pkg::reg_addr_w-1:0] s_axi_awaddr,
    input  wire s_axi_wvalid,
    output wire s_axi_wready,
    input  wire [round_trip_pkg::data_w-1:0] s_axi_wdata,
    output wire s_axi_bvalid,
    input  wire s_axi_bready,
    output wire m_axi_arvalid,
    input  wire m_axi_arready,
    output wire [round_trip_pkg::host_addr_w-1:0] m_axi_araddr,
    input  wire m_axi_rvalid,
    output wire m_axi_rready,
    input  wire [round_trip_pkg::data_w-1:0] m_axi_rdata,
    output wire m_axi_awvalid,
    input  wire m_axi_awready,
    output wire [round_trip_pkg::host_addr_w-1:0] m_axi_awaddr,
    output wire m_axi_wvalid,
    input  wire m_axi_wready,
    output wire [round_trip_pkg::data_w-1:0] m_axi_wdata,
    input  wire m_axi_bvalid,
    output wire m_axi_bready
);

    wire start;
    wire done;
    wire [round_trip_pkg::host_addr_w-1:0] base;
    wire [round_trip_pkg::host_addr_w-1:0] run_base;
    wire fetch_go;
    wire fetch_finished;
    wire wb_go;
    wire wb_finished;

    buffer_port_if fetch_bus ();
    buffer_port_if wb_bus ();
    buffer_port_if buf_bus ();

    ctrl_regs u_ctrl_regs (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .s_axi_arvalid(s_axi_arvalid),
        .s_axi_arready(s_axi_arready),
        .s_axi_araddr(s_axi_araddr),
        .s_axi_rvalid(s_axi_rvalid),
        .s_axi_rready(s_axi_rready),
        .s_axi_rdata(s_axi_rdata),
        .s_axi_awvalid(s_axi_awvalid),
        .s_axi_awready(s_axi_awready),
        .s_axi_awaddr(s_axi_awaddr),
        .s_axi_wvalid(s_axi_wvalid),
        .s_axi_wready(s_axi_wready),
        .s_axi_wdata(s_axi_wdata),
        .s_axi_bvalid(s_axi_bvalid),
        .s_axi_bready(s_axi_bready),
        .done(done),
        .start(start),
        .base(base)
    );

    transfer_sequencer u_transfer_sequencer (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .start(start),
        .base(base),
        .done(done),
        .fetch_go(fetch_go),
        .fetch_finished(fetch_finished),
        .wb_go(wb_go),
        .wb_finished(wb_finished),
        .run_base(run_base),
        .fetch_port(fetch_bus.mem),
        .wb_port(wb_bus.mem),
        .buf_port(buf_bus.client)
    );

    fetch_engine u_fetch_engine (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .go(fetch_go),
        .base(run_base),
        .finished(fetch_finished),
        .m_axi_arvalid(m_axi_arvalid),
        .m_axi_arready(m_axi_arready),
        .m_axi_araddr(m_axi_araddr),
        .m_axi_rvalid(m_axi_rvalid),
        .m_axi_rready(m_axi_rready),
        .m_axi_rdata(m_axi_rdata),
        .buf_port(fetch_bus.client)
    );

    writeback_engine u_writeback_engine (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .go(wb_go),
        .base(run_base),
        .finished(wb_finished),
        .m_axi_awvalid(m_axi_awvalid),
        .m_axi_awready(m_axi_awready),
        .m_axi_awaddr(m_axi_awaddr),
        .m_axi_wvalid(m_axi_wvalid),
        .m_axi_wready(m_axi_wready),
        .m_axi_wdata(m_axi_wdata),
        .m_axi_bvalid(m_axi_bvalid),
        .m_axi_bready(m_axi_bready),
        .buf_port(wb_bus.client)
    );

    word_buffer u_word_buffer (
        .ACLK(ACLK),
        .port(buf_bus.mem)
    );

endmodule

`default_nettype wire

// File: verif/round_trip_checker.sv
`timescale 1ns/1ps
`default_nettype none

module round_trip_checker (
    input wire ACLK,
    input wire ARESET,
    input wire m_axi_arvalid,
    input wire m_axi_arready,
    input wire [round_trip_pkg::host_addr_w-1:0] m_axi_araddr,
    input wire m_axi_rready,
    input wire m_axi_awvalid,
    input wire m_axi_awready,
    input wire [round_trip_pkg::host_addr_w-1:0] m_axi_awaddr,
    input wire m_axi_wvalid,
    input wire m_axi_wready,
    input wire m_axi_bready,
    input wire [1:0] phase
);

    logic aw_seen;
    logic read_busy;
    logic write_busy;

    assign read_busy = m_axi_arvalid || m_axi_rready;
    assign write_busy = m_axi_awvalid || m_axi_wvalid || m_axi_bready;

    // Set by the aw handshake of a word and cleared by its w handshake.
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_seen <= 1'b0;
        end else if (m_axi_awvalid && m_axi_awready) begin
            aw_seen <= 1'b1;
        end else if (m_axi_wvalid && m_axi_wready) begin
            aw_seen <= 1'b0;
        end
    end

    ar_held: assert property (@(posedge ACLK) disable iff (ARESET)
        m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr))
        else $error("arvalid or araddr changed before arready");

    aw_held: assert property (@(posedge ACLK) disable iff (ARESET)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
        else $error("awvalid or awaddr changed before awready");

    w_after_aw: assert property (@(posedge ACLK) disable iff (ARESET)
        m_axi_wvalid |-> aw_seen)
        else $error("wvalid raised before the aw handshake");

    one_direction: assert property (@(posedge ACLK) disable iff (ARESET)
        !(read_busy && write_busy))
        else $error("host read and host write pending together");

    reads_in_fetch: assert property (@(posedge ACLK) disable iff (ARESET)
        m_axi_arvalid |-> phase == round_trip_pkg::phase_fetch)
        else $error("host read outside the fetch phase");

endmodule

bind round_trip_top round_trip_checker u_round_trip_checker (
    .ACLK(ACLK),
    .ARESET(ARESET),
    .m_axi_arvalid(m_axi_arvalid),
    .m_axi_arready(m_axi_arready),
    .m_axi_araddr(m_axi_araddr),
    .m_axi_rready(m_axi_rready),
    .m_axi_awvalid(m_axi_awvalid),
    .m_axi_awready(m_axi_awready),
    .m_axi_awaddr(m_axi_awaddr),
    .m_axi_wvalid(m_axi_wvalid),
    .m_axi_wready(m_axi_wready),
    .m_axi_bready(m_axi_bready),
    .phase(u_transfer_sequencer.phase)
);

`default_nettype wire

// File: verif/tb_round_trip.sv
`timescale 1ns/1ps
`default_nettype none

module tb_round_trip;

    localparam int timeout_cycles = 2000;
    localparam logic [31:0] seed = 32'hd3d7_3418;

    logic ACLK = 1'b0;
    logic ARESET;
    logic s_axi_arvalid;
    logic s_axi_arready;
    logic [round_trip_pkg::reg_addr_w-1:0] s_axi_araddr;
    logic s_axi_rvalid;
    logic s_axi_rready;
    logic [round_trip_pkg::data_w-1:0] s_axi_rdata;
    logic s_axi_awvalid;
    logic s_axi_awready;
    logic [round_trip_pkg::reg_addr_w-1:0] s_axi_awaddr;
    logic s_axi_wvalid;
    logic s_axi_wready;
    logic [round_trip_pkg::data_w-1:0] s_axi_wdata;
    logic s_axi_bvalid;
    logic s_axi_bready;
    logic m_axi_arvalid;
    logic m_axi_arready = 1'b0;
    logic [round_trip_pkg::host_addr_w-1:0] m_axi_araddr;
    logic m_axi_rvalid = 1'b0;
    logic m_axi_rready;
    logic [round_trip_pkg::data_w-1:0] m_axi_rdata = '0;
    logic m_axi_awvalid;
    logic m_axi_awready = 1'b0;
    logic [round_trip_pkg::host_addr_w-1:0] m_axi_awaddr;
    logic m_axi_wvalid;
    logic m_axi_wready = 1'b0;
    logic [round_trip_pkg::data_w-1:0] m_axi_wdata;
    logic m_axi_bvalid = 1'b0;
    logic m_axi_bready;

    // Host memory model state.
    logic [round_trip_pkg::data_w-1:0] host_mem [logic [round_trip_pkg::host_addr_w-1:0]];
    logic [round_trip_pkg::host_addr_w-1:0] rd_addr_log [$];
    logic [round_trip_pkg::data_w-1:0] rd_data_log [$];
    logic [round_trip_pkg::host_addr_w-1:0] wr_addr_log [$];
    logic [round_trip_pkg::data_w-1:0] wr_data_log [$];
    logic [round_trip_pkg::host_addr_w-1:0] pending_raddr = '0;
    logic [round_trip_pkg::host_addr_w-1:0] pending_waddr = '0;
    logic [31:0] rng_state = seed;
    bit random_delays = 1'b0;
    bit r_pending = 1'b0;
    bit b_pending = 1'b0;
    int write_responses = 0;
    int ar_delay = 0;
    int r_delay = 0;
    int aw_delay = 0;
    int w_delay = 0;
    int b_delay = 0;

    always #50 ACLK = ~ACLK;

    round_trip_top u_round_trip_top (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Unwritten host memory holds a pattern derived from the full address.
    function automatic logic [31:0] fill_word(input logic [63:0] addr);
        return xorshift32(seed ^ addr[31:0] ^ {addr[47:32], addr[63:48]});
    endfunction

    function automatic logic [31:0] host_read(input logic [63:0] addr);
        if (host_mem.exists(addr)) begin
            return host_mem[addr];
        end
        return fill_word(addr);
    endfunction

    function automatic int draw_delay();
        if (!random_delays) begin
            return 0;
        end
        rng_state = xorshift32(rng_state);
        return int'(rng_state[1:0]);
    endfunction

    // Single-beat host memory. Every ready or valid waits a drawn number of cycles.
    always @(posedge ACLK) begin
        if (ARESET) begin
            m_axi_arready <= 1'b0;
            m_axi_rvalid <= 1'b0;
            m_axi_awready <= 1'b0;
            m_axi_wready <= 1'b0;
            m_axi_bvalid <= 1'b0;
            r_pending <= 1'b0;
            b_pending <= 1'b0;
        end else begin
            if (m_axi_arvalid && m_axi_arready) begin
                m_axi_arready <= 1'b0;
                ar_delay <= draw_delay();
                pending_raddr <= m_axi_araddr;
                r_pending <= 1'b1;
                r_delay <= draw_delay();
                rd_addr_log.push_back(m_axi_araddr);
            end else if (m_axi_arvalid) begin
                if (ar_delay == 0) begin
                    m_axi_arready <= 1'b1;
                end else begin
                    ar_delay <= ar_delay - 1;
                end
            end
            if (m_axi_rvalid && m_axi_rready) begin
                m_axi_rvalid <= 1'b0;
                rd_data_log.push_back(m_axi_rdata);
            end else if (r_pending) begin
                if (r_delay == 0) begin
                    m_axi_rvalid <= 1'b1;
                    m_axi_rdata <= host_read(pending_raddr);
                    r_pending <= 1'b0;
                end else begin
                    r_delay <= r_delay - 1;
                end
            end
            if (m_axi_awvalid && m_axi_awready) begin
                m_axi_awready <= 1'b0;
                aw_delay <= draw_delay();
                pending_waddr <= m_axi_awaddr;
            end else if (m_axi_awvalid) begin
                if (aw_delay == 0) begin
                    m_axi_awready <= 1'b1;
                end else begin
                    aw_delay <= aw_delay - 1;
                end
            end
            if (m_axi_wvalid && m_axi_wready) begin
                m_axi_wready <= 1'b0;
                w_delay <= draw_delay();
                host_mem[pending_waddr] = m_axi_wdata;
                wr_addr_log.push_back(pending_waddr);
                wr_data_log.push_back(m_axi_wdata);
                b_pending <= 1'b1;
                b_delay <= draw_delay();
            end else if (m_axi_wvalid) begin
                if (w_delay == 0) begin
                    m_axi_wready <= 1'b1;
                end else begin
                    w_delay <= w_delay - 1;
                end
            end
            if (m_axi_bvalid && m_axi_bready) begin
                m_axi_bvalid <= 1'b0;
                write_responses <= write_responses + 1;
            end else if (b_pending) begin
                if (b_delay == 0) begin
                    m_axi_bvalid <= 1'b1;
                    b_pending <= 1'b0;
                end else begin
                    b_delay <= b_delay - 1;
                end
            end
        end
    end

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic count_cycle(inout int cycles, input string what);
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("Timed out waiting for %s", what);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input logic [round_trip_pkg::data_w-1:0] got,
                              input logic [round_trip_pkg::data_w-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name,
                              input logic [round_trip_pkg::host_addr_w-1:0] got,
                              input logic [round_trip_pkg::host_addr_w-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%016h expected 0x%016h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_status(input string name, input round_trip_pkg::ctrl_word_u got,
                                input round_trip_pkg::ctrl_word_u exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic axil_write(input logic [round_trip_pkg::reg_addr_w-1:0] addr,
                              input logic [round_trip_pkg::data_w-1:0] data);
        int cycles;
        @(posedge ACLK);
        s_axi_awvalid <= 1'b1;
        s_axi_awaddr <= addr;
        cycles = 0;
        do begin
            @(negedge ACLK);
            count_cycle(cycles, "s_axi_awready");
        end while (s_axi_awready !== 1'b1);
        @(posedge ACLK);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid <= 1'b1;
        s_axi_wdata <= data;
        cycles = 0;
        do begin
            @(negedge ACLK);
            count_cycle(cycles, "s_axi_wready");
        end while (s_axi_wready !== 1'b1);
        @(posedge ACLK);
        s_axi_wvalid <= 1'b0;
        s_axi_bready <= 1'b1;
        cycles = 0;
        do begin
            @(negedge ACLK);
            count_cycle(cycles, "s_axi_bvalid");
        end while (s_axi_bvalid !== 1'b1);
        @(posedge ACLK);
        s_axi_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [round_trip_pkg::reg_addr_w-1:0] addr,
                             output logic [round_trip_pkg::data_w-1:0] data);
        int cycles;
        @(posedge ACLK);
        s_axi_arvalid <= 1'b1;
        s_axi_araddr <= addr;
        cycles = 0;
        do begin
            @(negedge ACLK);
            count_cycle(cycles, "s_axi_arready");
        end while (s_axi_arready !== 1'b1);
        @(posedge ACLK);
        s_axi_arvalid <= 1'b0;
        s_axi_rready <= 1'b1;
        cycles = 0;
        do begin
            @(negedge ACLK);
            count_cycle(cycles, "s_axi_rvalid");
        end while (s_axi_rvalid !== 1'b1);
        data = s_axi_rdata;
        @(posedge ACLK);
        s_axi_rready <= 1'b0;
    endtask

    task automatic reset_state();
        round_trip_pkg::ctrl_word_u status;
        round_trip_pkg::ctrl_word_u exp;
        logic [round_trip_pkg::data_w-1:0] data;
        exp = '0;
        exp.rd.idle = 1'b1;
        axil_read(round_trip_pkg::reg_ctrl, status);
        check_status("ctrl status after reset", status, exp);
        axil_read(round_trip_pkg::reg_base_lo, data);
        check_word("base_lo after reset", data, '0);
        axil_read(round_trip_pkg::reg_base_hi, data);
        check_word("base_hi after reset", data, '0);
        @(negedge ACLK);
        check_flag("m_axi_arvalid", m_axi_arvalid, 1'b0);
        check_flag("m_axi_awvalid", m_axi_awvalid, 1'b0);
    endtask

    task automatic register_access(input logic [round_trip_pkg::host_addr_w-1:0] base);
        logic [round_trip_pkg::data_w-1:0] data;
        logic [round_trip_pkg::host_addr_w-1:0] readback;
        axil_write(round_trip_pkg::reg_base_lo, base[31:0]);
        axil_write(round_trip_pkg::reg_base_hi, base[63:32]);
        axil_read(round_trip_pkg::reg_base_lo, readback[31:0]);
        axil_read(round_trip_pkg::reg_base_hi, readback[63:32]);
        check_addr("base readback", readback, base);
        axil_write(12'h010, 32'hdead_beef);
        axil_read(12'h010, data);
        check_word("unmapped offset 0x010", data, '0);
    endtask

    task automatic await_done(input int resp_first);
        round_trip_pkg::ctrl_word_u status;
        round_trip_pkg::ctrl_word_u exp;
        int cycles;
        cycles = 0;
        do begin
            @(negedge ACLK);
            count_cycle(cycles, "the last host write response");
        end while (write_responses < resp_first + round_trip_pkg::words);
        // Done lands one edge after the engine's finished pulse, and a read of the
        // control word in flight across that edge would clear it unseen.
        repeat (2) @(posedge ACLK);
        cycles = 0;
        do begin
            axil_read(round_trip_pkg::reg_ctrl, status);
            count_cycle(cycles, "done in the control word");
        end while (status.rd.done !== 1'b1);
        exp = '0;
        exp.rd.done = 1'b1;
        exp.rd.idle = 1'b1;
        check_status("ctrl status at completion", status, exp);
        axil_read(round_trip_pkg::reg_ctrl, status);
        exp.rd.done = 1'b0;
        check_status("ctrl status after done was read", status, exp);
    endtask

    task automatic round_trip(input logic [round_trip_pkg::host_addr_w-1:0] base,
                              input bit with_delays);
        int rd_first;
        int wr_first;
        int resp_first;
        int i;
        logic [round_trip_pkg::host_addr_w-1:0] addr;
        random_delays = with_delays;
        rd_first = rd_addr_log.size();
        wr_first = wr_addr_log.size();
        resp_first = write_responses;
        axil_write(round_trip_pkg::reg_base_lo, base[31:0]);
        axil_write(round_trip_pkg::reg_base_hi, base[63:32]);
        axil_write(round_trip_pkg::reg_ctrl, 32'h1);
        await_done(resp_first);
        check_word("host read count", 32'(rd_addr_log.size() - rd_first), 32'(8));
        check_word("host write count", 32'(wr_addr_log.size() - wr_first), 32'(8));
        for (i = 0; i < round_trip_pkg::words; i++) begin
            addr = base + 64'(4 * i);
            check_addr("m_axi_araddr", rd_addr_log[rd_first + i], addr);
            check_addr("m_axi_awaddr", wr_addr_log[wr_first + i], addr);
            check_word("m_axi_wdata", wr_data_log[wr_first + i], rd_data_log[rd_first + i]);
        end
    endtask

    task automatic rerun_with_backpressure(input logic [63:0] first_base,
                                           input logic [63:0] base);
        int i;
        logic [63:0] addr;
        round_trip(base, 1'b1);
        check_word("host memory entries", 32'(host_mem.num()), 32'(2 * round_trip_pkg::words));
        check_flag("write below run", 1'(host_mem.exists(base - 64'd4)), 1'b0);
        check_flag("write above run", 1'(host_mem.exists(base + 64'd32)), 1'b0);
        for (i = 0; i < round_trip_pkg::words; i++) begin
            addr = first_base + 64'(4 * i);
            check_word("first run word", host_mem[addr], fill_word(addr));
        end
    endtask

    initial begin
        ARESET = 1'b1;
        s_axi_arvalid = 1'b0;
        s_axi_araddr = '0;
        s_axi_rready = 1'b0;
        s_axi_awvalid = 1'b0;
        s_axi_awaddr = '0;
        s_axi_wvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_bready = 1'b0;
        repeat (10) @(posedge ACLK);
        ARESET <= 1'b0;
        reset_state();
        register_access(64'h0000_0012_3456_7000);
        round_trip(64'h0000_0012_3456_7000, 1'b0);
        rerun_with_backpressure(64'h0000_0012_3456_7000, 64'h0000_00ab_cdef_0100);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/round_trip_pkg.sv
hw/buffer_port_if.sv
hw/ctrl_regs.sv
hw/transfer_sequencer.sv
hw/fetch_engine.sv
hw/writeback_engine.sv
hw/word_buffer.sv
hw/round_trip_top.sv
verif/round_trip_checker.sv
verif/tb_round_trip.sv

// File: Makefile
TOP := tb_round_trip

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
